/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_adc_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/adc_pkg.sv */
/*
  shared definitions for the multi-slope ADC controller.
  register map, switch codes, phase timing and the bus structs.
*/
package adc_pkg;

  ///////////////////////////////////////////////////////////////////////
  // spi framing and register map.

  // one frame is an address byte followed by a value byte.
  localparam int unsigned FRAME_BITS = 16;

  // writable registers.
  localparam logic [7:0] ADDR_LED      = 8'h07;
  localparam logic [7:0] ADDR_CTRL     = 8'h08;
  localparam logic [7:0] ADDR_SOFT_RST = 8'h0B;

  // read-only result registers, little end first.
  localparam logic [7:0] ADDR_RD_LO  = 8'h10;
  localparam logic [7:0] ADDR_RD_HI  = 8'h11;
  localparam logic [7:0] ADDR_UP_LO  = 8'h12;
  localparam logic [7:0] ADDR_UP_HI  = 8'h13;
  localparam logic [7:0] ADDR_STATUS = 8'h14;

  // led pattern restored by a soft reset.
  localparam logic [3:0] LED_RESET_VAL = 4'b0101;

  ///////////////////////////////////////////////////////////////////////
  // conversion timing, kept short so a simulation finishes quickly.

  localparam int unsigned PHASE_LEN   = 20;
  localparam int unsigned PHASES      = 8;
  localparam int unsigned RUNDOWN_MAX = 200;

  // width of every conversion counter.
  localparam int unsigned CNT_W = 16;

  // integrator input switches, {sig, n, p}.
  localparam logic [2:0] MUX_OFF  = 3'b000;
  localparam logic [2:0] MUX_DOWN = 3'b001;
  localparam logic [2:0] MUX_UP   = 3'b010;

  typedef enum logic [1:0] {
    INIT,
    RUNUP,
    RUNDOWN,
    DONE
  } adc_state_t;

  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] val;
  } spi_frame_t;

  typedef struct packed {
    logic run;
  } adc_config_t;

  typedef struct packed {
    logic [CNT_W-1:0] rundown_count;
    logic [CNT_W-1:0] up_count;
    logic [CNT_W-1:0] down_count;
    logic             overrange;
  } adc_result_t;

endpackage

/* design/adc_top.sv */
/*
  integrating ADC controller top level.
  spi receiver, register bank and run-up controller.
*/
`timescale 1ns/1ns

module adc_top
  import adc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       spi_sclk,
  input  logic       spi_cs_n,
  input  logic       spi_mosi,
  output logic       spi_miso,
  input  logic       cmp_out,
  output logic [2:0] mux_ctl,
  output logic [2:0] led,
  output logic       result_ready
);

  spi_frame_t            frame;
  logic                  frame_valid;
  logic [FRAME_BITS-1:0] rd_word;
  adc_config_t           cfg;
  adc_result_t           result;
  logic                  done;
  logic [3:0]            led_reg;

  spi_frame_rx spi_frame_rx_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (spi_sclk),
    .cs_n        (spi_cs_n),
    .mosi        (spi_mosi),
    .miso        (spi_miso),
    .rd_word     (rd_word),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  reg_bank reg_bank_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .frame        (frame),
    .frame_valid  (frame_valid),
    .rd_word      (rd_word),
    .cfg          (cfg),
    .result       (result),
    .done         (done),
    .led          (led_reg),
    .result_ready (result_ready)
  );

  runup_ctrl runup_ctrl_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg     (cfg),
    .cmp_out (cmp_out),
    .mux_ctl (mux_ctl),
    .result  (result),
    .done    (done)
  );

  // board has three leds, {b, g, r}.
  assign led = led_reg[2:0];

endmodule

/* design/reg_bank.sv */
/*
  spi register bank. set/clear/toggle writes, soft reset,
  result latch with read-to-clear status and readback mux.
*/
`timescale 1ns/1ns

module reg_bank
  import adc_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  spi_frame_t            frame,
  input  logic                  frame_valid,
  output logic [FRAME_BITS-1:0] rd_word,
  output adc_config_t           cfg,
  input  adc_result_t           result,
  input  logic                  done,
  output logic [3:0]            led,
  output logic                  result_ready
);

  logic        run_q;
  logic [7:0]  last_addr;
  logic [7:0]  rd_data;
  logic [3:0]  led_upd;
  logic [3:0]  ctrl_upd;
  adc_result_t result_q;

  // low nibble sets, high nibble clears.
  // a bit named in both nibbles toggles instead.
  function automatic logic [3:0] nibble_update(input logic [3:0] cur, input logic [7:0] val);
    logic [3:0] set_n;
    logic [3:0] clr_n;
    logic [3:0] both;
    set_n = val[3:0];
    clr_n = val[7:4];
    both  = set_n & clr_n;
    if (|both)
      return cur ^ both;
    else
      return (cur | set_n) & ~clr_n;
  endfunction

  assign led_upd  = nibble_update(led, frame.val);
  // ctrl only has the run bit, so it rides in bit 0.
  assign ctrl_upd = nibble_update({3'b000, run_q}, frame.val);

  ///////////////////////////////////////////////////////////////////////
  // register writes and status.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      led          <= 4'b0000;
      run_q        <= 1'b0;
      last_addr    <= '0;
      result_ready <= 1'b0;
      result_q     <= '0;
    end
    else
    begin
      if (frame_valid)
      begin
        // remembered for the next frame's readback.
        last_addr <= frame.addr;
        case (frame.addr)
          ADDR_LED:
            led <= led_upd;
          ADDR_CTRL:
            run_q <= ctrl_upd[0];
          ADDR_SOFT_RST:
          begin
            led   <= LED_RESET_VAL;
            run_q <= 1'b0;
          end
          ADDR_STATUS:
            result_ready <= 1'b0;
          default:
            ;
        endcase
      end
      // a fresh result wins over a status read in the same cycle.
      if (done)
      begin
        result_q     <= result;
        result_ready <= 1'b1;
      end
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // readback.

  always_comb
  begin
    case (last_addr)
      ADDR_LED:    rd_data = {4'b0000, led};
      ADDR_CTRL:   rd_data = {7'b0000000, run_q};
      ADDR_RD_LO:  rd_data = result_q.rundown_count[7:0];
      ADDR_RD_HI:  rd_data = result_q.rundown_count[15:8];
      ADDR_UP_LO:  rd_data = result_q.up_count[7:0];
      ADDR_UP_HI:  rd_data = result_q.up_count[15:8];
      ADDR_STATUS: rd_data = {6'b000000, result_q.overrange, result_ready};
      default:     rd_data = 8'h00;
    endcase
  end

  assign rd_word = {last_addr, rd_data};
  assign cfg.run = run_q;

endmodule

/* files.f */
common/adc_pkg.sv
spi/spi_frame_rx.sv
design/reg_bank.sv
integrator/runup_ctrl.sv
design/adc_top.sv
testbench/tb_adc_top.sv

/* integrator/runup_ctrl.sv */
/*
  multi-slope run-up and run-down controller.
  steers the integrator switches from the comparator and counts the result.
*/
`timescale 1ns/1ns

module runup_ctrl
  import adc_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  adc_config_t cfg,
  input  logic        cmp_out,
  output logic [2:0]  mux_ctl,
  output adc_result_t result,
  output logic        done
);

  logic [2:0] cmp_sync;
  logic       cmp_s;
  logic       cmp_cross;

  adc_state_t       state;
  logic [CNT_W-1:0] cycle_cnt;
  logic [CNT_W-1:0] phase_cnt;
  logic [CNT_W-1:0] up_cnt;
  logic [CNT_W-1:0] down_cnt;
  logic [CNT_W-1:0] rundown_cnt;
  logic [CNT_W-1:0] rundown_next;
  logic             phase_end;
  logic             last_phase;
  logic             rundown_stop;

  ///////////////////////////////////////////////////////////////////////
  // comparator synchronizer.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cmp_sync <= 3'b000;
    else
      cmp_sync <= {cmp_sync[1:0], cmp_out};
  end

  // level after two flops.
  assign cmp_s = cmp_sync[1];
  // either direction counts as a zero crossing.
  assign cmp_cross = cmp_sync[2] ^ cmp_sync[1];

  assign phase_end    = (cycle_cnt == CNT_W'(PHASE_LEN - 1));
  assign last_phase   = (phase_cnt == CNT_W'(PHASES - 1));
  assign rundown_next = rundown_cnt + 1'b1;
  // stop on the crossing, or give up at the limit.
  assign rundown_stop = cmp_cross || (rundown_next == CNT_W'(RUNDOWN_MAX));

  ///////////////////////////////////////////////////////////////////////
  // state machine.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= INIT;
      mux_ctl     <= MUX_OFF;
      cycle_cnt   <= '0;
      phase_cnt   <= '0;
      up_cnt      <= '0;
      down_cnt    <= '0;
      rundown_cnt <= '0;
      done        <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        INIT:
        begin
          // hold here with the switches open until run is set.
          if (cfg.run)
          begin
            cycle_cnt   <= '0;
            phase_cnt   <= '0;
            up_cnt      <= '0;
            down_cnt    <= '0;
            rundown_cnt <= '0;
            // first phase always goes down.
            mux_ctl     <= MUX_DOWN;
            state       <= RUNUP;
          end
          else
            mux_ctl <= MUX_OFF;
        end

        RUNUP:
        begin
          if (phase_end)
          begin
            cycle_cnt <= '0;
            phase_cnt <= phase_cnt + 1'b1;
            // comparator picks the next direction.
            if (cmp_s)
            begin
              mux_ctl <= MUX_UP;
              up_cnt  <= up_cnt + 1'b1;
            end
            else
            begin
              mux_ctl  <= MUX_DOWN;
              down_cnt <= down_cnt + 1'b1;
            end
            if (last_phase)
            begin
              rundown_cnt <= '0;
              state       <= RUNDOWN;
            end
          end
          else
            cycle_cnt <= cycle_cnt + 1'b1;
        end

        RUNDOWN:
        begin
          // direction from the last phase stays on.
          rundown_cnt <= rundown_next;
          if (rundown_stop)
          begin
            mux_ctl <= MUX_OFF;
            done    <= 1'b1;
            state   <= DONE;
          end
        end

        DONE:
        begin
          if (cfg.run)
            state <= INIT;
        end

        default:
          state <= INIT;
      endcase
    end
  end

  // result is captured together with the done pulse.
  always_ff @(posedge clk)
  begin
    if (state == RUNDOWN && rundown_stop)
    begin
      result.rundown_count <= rundown_next;
      result.up_count      <= up_cnt;
      result.down_count    <= down_cnt;
      result.overrange     <= ~cmp_cross;
    end
  end

endmodule

/* spi/spi_frame_rx.sv */
/*
  spi mode 0 slave, oversampled in the system clock domain.
  assembles 16-bit frames and shifts out the readback word.
*/
`timescale 1ns/1ns

module spi_frame_rx
  import adc_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  sclk,
  input  logic                  cs_n,
  input  logic                  mosi,
  output logic                  miso,
  input  logic [FRAME_BITS-1:0] rd_word,
  output spi_frame_t            frame,
  output logic                  frame_valid
);

  // one extra bit so over-long frames are told apart.
  localparam int unsigned BIT_CNT_W = $clog2(FRAME_BITS) + 1;

  logic [1:0] sclk_sync;
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sclk_q;
  logic       cs_q;
  logic       sclk_s;
  logic       cs_s;
  logic       mosi_s;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       cs_rise;
  logic       cs_fall;

  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [FRAME_BITS-1:0] rx_shift;
  logic [FRAME_BITS-1:0] tx_shift;

  ///////////////////////////////////////////////////////////////////////
  // two flop synchronizers, then one more flop for the edge detect.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk_sync <= 2'b00;
      cs_sync   <= 2'b11;
      mosi_sync <= 2'b00;
      sclk_q    <= 1'b0;
      // idle chip select is high, so no false edge leaving reset.
      cs_q      <= 1'b1;
    end
    else
    begin
      sclk_sync <= {sclk_sync[0], sclk};
      cs_sync   <= {cs_sync[0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
      sclk_q    <= sclk_sync[1];
      cs_q      <= cs_sync[1];
    end
  end

  assign sclk_s    = sclk_sync[1];
  assign cs_s      = cs_sync[1];
  assign mosi_s    = mosi_sync[1];
  assign sclk_rise = sclk_s & ~sclk_q;
  assign sclk_fall = ~sclk_s & sclk_q;
  assign cs_rise   = cs_s & ~cs_q;
  assign cs_fall   = ~cs_s & cs_q;

  ///////////////////////////////////////////////////////////////////////
  // bit counter, readback shifter and frame strobe.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt     <= '0;
      tx_shift    <= '0;
      frame_valid <= 1'b0;
    end
    else
    begin
      frame_valid <= 1'b0;
      if (cs_fall)
      begin
        // new frame, preload the readback word.
        bit_cnt  <= '0;
        tx_shift <= rd_word;
      end
      else if (!cs_s)
      begin
        // saturate so long frames never wrap back to a valid count.
        if (sclk_rise && bit_cnt != '1)
          bit_cnt <= bit_cnt + 1'b1;
        // mode 0, master samples on rise so we move on the fall.
        if (sclk_fall)
          tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
      end
      // only a frame of exactly the right length is passed on.
      if (cs_rise && bit_cnt == BIT_CNT_W'(FRAME_BITS))
        frame_valid <= 1'b1;
    end
  end

  // msb first, lsb enters at the bottom.
  always_ff @(posedge clk)
  begin
    if (!cs_s && sclk_rise)
      rx_shift <= {rx_shift[FRAME_BITS-2:0], mosi_s};
  end

  assign frame = spi_frame_t'(rx_shift);
  assign miso  = tx_shift[FRAME_BITS-1];

endmodule

/* testbench/tb_adc_top.sv */
/*
  testbench for the integrating ADC controller.
  table-driven spi frames, then two conversions against a comparator model.
*/
`timescale 1ns/1ns

module tb_adc_top
  import adc_pkg::*;
();

  // one spi frame and what it should leave behind.
  typedef struct packed {
    logic [7:0]  addr;
    logic [7:0]  val;
    logic [4:0]  bits;
    logic [3:0]  led;
    logic [15:0] rd;
  } frame_case_t;

  localparam int N_CASES = 15;
  localparam int WAIT_LIMIT = 1000;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       spi_sclk;
  logic       spi_cs_n;
  logic       spi_mosi;
  logic       spi_miso;
  logic       cmp_out = 1'b0;
  logic [2:0] mux_ctl;
  logic [2:0] led;
  logic       result_ready;

  frame_case_t cases [N_CASES];
  int          errors = 0;
  int          checks = 0;

  // comparator model state.
  int   integ = 0;
  int   model_cycles = 0;
  int   flip_cycle = 32'h7fff_ffff;
  logic cmp_force = 1'b0;
  logic swap_now;
  logic force_now;

  adc_top adc_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .spi_sclk     (spi_sclk),
    .spi_cs_n     (spi_cs_n),
    .spi_mosi     (spi_mosi),
    .spi_miso     (spi_miso),
    .cmp_out      (cmp_out),
    .mux_ctl      (mux_ctl),
    .led          (led),
    .result_ready (result_ready)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // integrator model.
  // climbs on MUX_UP, falls on MUX_DOWN, comparator is integ above zero.
  // the comparator leads start swapped and flip at a random cycle,
  // which turns the loop into negative feedback.

  always @(posedge clk)
  begin
    model_cycles = model_cycles + 1;
    swap_now     = (model_cycles >= flip_cycle);
    force_now    = cmp_force;
    #10;
    if (mux_ctl == MUX_UP)
      integ = integ + 1;
    else if (mux_ctl == MUX_DOWN)
      integ = integ - 1;
    if (force_now)
      cmp_out = 1'b1;
    else
      cmp_out = (integ > 0) ^ swap_now;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers.

  // advance n clocks, land 10 ns after the edge.
  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #10;
  endtask

  task automatic compare_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  function automatic frame_case_t make_case(input logic [7:0] addr, input logic [7:0] val,
                                            input int bits, input logic [3:0] led_exp,
                                            input logic [15:0] rd_exp);
    frame_case_t c;
    c.addr = addr;
    c.val  = val;
    c.bits = 5'(bits);
    c.led  = led_exp;
    c.rd   = rd_exp;
    return c;
  endfunction

  // bit-banged mode 0 frame, msb first, miso captured on each rising sclk.
  task automatic send_frame(input logic [15:0] word, input int nbits,
                            output logic [15:0] rd);
    int i;
    rd       = '0;
    spi_cs_n = 1'b0;
    tick(5);
    for (i = 0; i < nbits; i++)
    begin
      // bits past the word are padding.
      spi_mosi = (i < 16) ? word[15 - i] : 1'b0;
      tick(5);
      spi_sclk = 1'b1;
      if (i < 16)
        rd[15 - i] = spi_miso;
      tick(5);
      spi_sclk = 1'b0;
    end
    tick(5);
    spi_cs_n = 1'b1;
    // led pins are looked at 10 clocks after cs_n rises.
    tick(10);
  endtask

  task automatic run_case(input frame_case_t c);
    logic [15:0] rd;
    logic [15:0] mask;
    int          nbits;
    nbits = int'(c.bits);
    send_frame({c.addr, c.val}, nbits, rd);
    // a short frame never clocks out the low bits.
    mask = (nbits < 16) ? (16'hFFFF << (16 - nbits)) : 16'hFFFF;
    compare_value("readback", rd & mask, c.rd & mask);
    compare_value("led", 16'(led), 16'(c.led[2:0]));
  endtask

  task automatic wait_ready(input int limit);
    int n;
    n = 0;
    while (result_ready !== 1'b1 && n < limit)
    begin
      tick(1);
      n++;
    end
    if (result_ready !== 1'b1)
    begin
      errors++;
      $display("timeout: result_ready did not rise within %0d cycles", limit);
    end
    else
      compare_value("mux_ctl", 16'(mux_ctl), 16'(MUX_OFF));
  endtask

  // switches stay open for a few clocks once the controller is parked.
  task automatic wait_idle(input int limit);
    int n;
    int quiet;
    n     = 0;
    quiet = 0;
    while (quiet < 4 && n < limit)
    begin
      if (mux_ctl == MUX_OFF)
        quiet++;
      else
        quiet = 0;
      tick(1);
      n++;
    end
    if (quiet < 4)
    begin
      errors++;
      $display("timeout: the integrator switches did not open within %0d cycles", limit);
    end
  endtask

  // each readback carries the previous frame's address.
  task automatic read_results(output logic [15:0] up, output logic [15:0] rdn,
                              output logic [7:0] status);
    logic [7:0]  addrs [6];
    logic [7:0]  data [5];
    logic [15:0] rd;
    int          i;
    addrs[0] = ADDR_UP_LO;
    addrs[1] = ADDR_UP_HI;
    addrs[2] = ADDR_RD_LO;
    addrs[3] = ADDR_RD_HI;
    addrs[4] = ADDR_STATUS;
    addrs[5] = 8'h3A;
    for (i = 0; i < 6; i++)
    begin
      send_frame({addrs[i], 8'h00}, 16, rd);
      if (i > 0)
      begin
        compare_value("readback address", {8'h00, rd[15:8]}, {8'h00, addrs[i - 1]});
        data[i - 1] = rd[7:0];
      end
    end
    up     = {data[1], data[0]};
    rdn    = {data[3], data[2]};
    status = data[4];
  endtask

  //////////////////////////////////////////////////////////////////////
  // frame table. low nibble sets, high nibble clears, shared bits toggle.

  task automatic fill_table();
    cases[0]  = make_case(ADDR_LED,      8'h03, 16, 4'h3, 16'h0000);
    cases[1]  = make_case(ADDR_LED,      8'h0C, 16, 4'hF, 16'h0703);
    cases[2]  = make_case(ADDR_LED,      8'h50, 16, 4'hA, 16'h070F);
    // set bit 0 and clear bit 1.
    cases[3]  = make_case(ADDR_LED,      8'h21, 16, 4'h9, 16'h070A);
    cases[4]  = make_case(ADDR_LED,      8'h33, 16, 4'hA, 16'h0709);
    // bit 2 toggles, bit 0 is left alone.
    cases[5]  = make_case(ADDR_LED,      8'h45, 16, 4'hE, 16'h070A);
    cases[6]  = make_case(8'h3A,         8'hFF, 16, 4'hE, 16'h070E);
    // wrong lengths are dropped.
    cases[7]  = make_case(ADDR_LED,      8'h0F, 15, 4'hE, 16'h3A00);
    cases[8]  = make_case(ADDR_LED,      8'hF0, 17, 4'hE, 16'h3A00);
    cases[9]  = make_case(ADDR_LED,      8'h00, 16, 4'hE, 16'h3A00);
    cases[10] = make_case(ADDR_SOFT_RST, 8'h00, 16, 4'h5, 16'h070E);
    cases[11] = make_case(ADDR_CTRL,     8'h00, 16, 4'h5, 16'h0B00);
    cases[12] = make_case(8'h3A,         8'h00, 16, 4'h5, 16'h0800);
    cases[13] = make_case(ADDR_LED,      8'h00, 16, 4'h5, 16'h3A00);
    cases[14] = make_case(8'h3A,         8'h00, 16, 4'h5, 16'h0705);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence.

  initial
  begin
    logic [15:0] rd;
    logic [15:0] up;
    logic [15:0] down;
    logic [15:0] rdn;
    logic [7:0]  status;
    int          i;
    rst_n    = 1'b0;
    spi_sclk = 1'b0;
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    void'($urandom(32'h18c3_cb7c));
    fill_table();
    repeat (16) @(posedge clk);
    #10;
    rst_n = 1'b1;
    tick(2);

    compare_value("led", 16'(led), 16'h0000);
    compare_value("mux_ctl", 16'(mux_ctl), 16'(MUX_OFF));
    compare_value("result_ready", 16'(result_ready), 16'h0000);
    compare_value("spi_miso", 16'(spi_miso), 16'h0000);

    for (i = 0; i < N_CASES; i++)
      run_case(cases[i]);

    // free-running conversion, comparator flips inside run-up.
    flip_cycle = model_cycles + 200 + int'($urandom % 60);
    send_frame({ADDR_CTRL, 8'h01}, 16, rd);
    wait_ready(WAIT_LIMIT);
    send_frame({ADDR_CTRL, 8'h10}, 16, rd);
    wait_idle(WAIT_LIMIT);
    // down_count has no register, read the latched result.
    down = adc_top_inst.reg_bank_inst.result_q.down_count;
    read_results(up, rdn, status);
    compare_value("up_count + down_count", up + down, 16'(PHASES));
    compare_value("status", {8'h00, status}, 16'h0000);
    compare_value("result_ready", 16'(result_ready), 16'h0000);

    // stuck-high comparator, run-down must hit the limit.
    cmp_force = 1'b1;
    send_frame({ADDR_CTRL, 8'h01}, 16, rd);
    wait_ready(WAIT_LIMIT);
    send_frame({ADDR_CTRL, 8'h10}, 16, rd);
    wait_idle(WAIT_LIMIT);
    compare_value("result_ready", 16'(result_ready), 16'h0001);
    down = adc_top_inst.reg_bank_inst.result_q.down_count;
    read_results(up, rdn, status);
    compare_value("up_count", up, 16'(PHASES));
    compare_value("down_count", down, 16'h0000);
    compare_value("rundown_count", rdn, 16'(RUNDOWN_MAX));
    compare_value("status", {8'h00, status}, 16'h0002);
    compare_value("result_ready", 16'(result_ready), 16'h0000);

    // soft reset drops run as well as restoring the leds.
    send_frame({ADDR_CTRL, 8'h01}, 16, rd);
    run_case(make_case(ADDR_SOFT_RST, 8'h00, 16, 4'h5, 16'h0801));
    run_case(make_case(ADDR_CTRL, 8'h00, 16, 4'h5, 16'h0B00));
    run_case(make_case(8'h3A, 8'h00, 16, 4'h5, 16'h0800));

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule
